/* source/lsu_isa_pkg.sv */
// ------------------------------
// load/store opcodes and operation types
// data TLB geometry and SPR map
// ------------------------------
package lsu_isa_pkg;

   // loads with bit 0 set zero extend
   localparam logic [5:0] opc_lwz = 6'h21;
   localparam logic [5:0] opc_lws = 6'h22;
   localparam logic [5:0] opc_lbz = 6'h23;
   localparam logic [5:0] opc_lbs = 6'h24;
   localparam logic [5:0] opc_lhz = 6'h25;
   localparam logic [5:0] opc_lhs = 6'h26;

   // stores sized by the two low bits
   localparam logic [5:0] opc_sw  = 6'h35;   // 01 word
   localparam logic [5:0] opc_sb  = 6'h36;   // 10 byte
   localparam logic [5:0] opc_sh  = 6'h37;   // 11 half

   localparam int tlb_sets      = 16;
   localparam int tlb_idx_bits  = $clog2(tlb_sets);
   localparam int tlb_page_bits = 12;   // 4 KiB pages

   // match entry is {tag[31:16], 15'b0, valid}
   // translate entry is {ppn[31:12], 10'b0, user, we}
   localparam logic [15:0] spr_dtlb_match_base = 16'h0800;
   localparam logic [15:0] spr_dtlb_trans_base = 16'h0880;

   typedef struct packed {
      logic        load;
      logic        store;
      logic [5:0]  opc;
      logic [31:0] adr;    // virtual address
      logic [31:0] rfb;    // store operand
   } lsu_op_t;

   typedef struct packed {
      logic align;
      logic dbus;          // bus error
      logic dtlb_miss;
      logic pagefault;
   } lsu_exc_t;

   typedef struct packed {
      logic [15:0] addr;
      logic        we;
      logic        stb;    // single cycle strobe
      logic [31:0] dat;
   } spr_req_t;

endpackage

/* source/mem_bus_pkg.sv */
// ------------------------------
// shared memory bus types
// ------------------------------
package mem_bus_pkg;

   localparam int ram_words = 256;   // 1 KiB of data RAM

   typedef struct packed {
      logic        req;    // level held until ack or err
      logic        we;
      logic [3:0]  bsel;   // bit 3 is lanes 31:24
      logic [31:0] adr;
      logic [31:0] dat;
   } bus_req_t;

   typedef struct packed {
      logic        ack;    // one cycle pulse
      logic        err;    // one cycle pulse
      logic [31:0] dat;
   } bus_rsp_t;

endpackage

/* source/lsu_dtlb.sv */
`timescale 1ns/1ns
// ------------------------------
// data TLB with 16 direct mapped pages
// entries filled and read back over SPR
// ------------------------------
module lsu_dtlb (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  enable_i,
   input  logic                  supervisor_i,
   input  logic [31:0]           virt_adr_i,
   input  logic                  store_i,
   input  logic                  access_i,
   input  lsu_isa_pkg::spr_req_t spr_i,
   output logic [31:0]           spr_dat_o,
   output logic                  spr_ack_o,
   output logic [31:0]           phys_adr_o,
   output logic                  miss_o,
   output logic                  pagefault_o
);
   import lsu_isa_pkg::*;

   logic [tlb_sets-1:0]     valid_r;
   logic [15:0]             tag_mem [tlb_sets];   // virtual bits 31:16
   logic [19:0]             ppn_mem [tlb_sets];   // physical page number
   logic [tlb_sets-1:0]     we_mem;               // page writable
   logic [tlb_sets-1:0]     user_mem;             // user mode allowed
   logic [tlb_idx_bits-1:0] idx;
   logic [tlb_idx_bits-1:0] spr_idx;
   logic                    hit;
   logic                    spr_match_sel;
   logic                    spr_trans_sel;
   logic                    spr_fire;

   assign idx = virt_adr_i[tlb_page_bits +: tlb_idx_bits];
   assign hit = valid_r[idx] &&
                (tag_mem[idx] == virt_adr_i[31:tlb_page_bits+tlb_idx_bits]);

   // untranslated when the MMU is off
   assign phys_adr_o  = enable_i ? {ppn_mem[idx], virt_adr_i[tlb_page_bits-1:0]}
                                 : virt_adr_i;
   assign miss_o      = enable_i & access_i & !hit;
   assign pagefault_o = enable_i & access_i & hit &
                        ((store_i & !we_mem[idx]) | (!supervisor_i & !user_mem[idx]));

   assign spr_idx       = spr_i.addr[tlb_idx_bits-1:0];
   assign spr_match_sel = spr_i.addr[15:tlb_idx_bits] == spr_dtlb_match_base[15:tlb_idx_bits];
   assign spr_trans_sel = spr_i.addr[15:tlb_idx_bits] == spr_dtlb_trans_base[15:tlb_idx_bits];
   assign spr_fire      = spr_i.stb & (spr_match_sel | spr_trans_sel) & !spr_ack_o;

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_r   <= '0;
         spr_ack_o <= 1'b0;
      end else begin
         spr_ack_o <= spr_fire;   // ack one cycle after stb
         if (spr_fire & spr_i.we & spr_match_sel)
            valid_r[spr_idx] <= spr_i.dat[0];
      end
   end

   always_ff @(posedge clk) begin
      if (spr_fire & spr_i.we & spr_match_sel)
         tag_mem[spr_idx] <= spr_i.dat[31:16];
      if (spr_fire & spr_i.we & spr_trans_sel) begin
         ppn_mem[spr_idx]  <= spr_i.dat[31:12];
         user_mem[spr_idx] <= spr_i.dat[1];
         we_mem[spr_idx]   <= spr_i.dat[0];
      end
      if (spr_fire & !spr_i.we) begin   // readback lands with the ack
         if (spr_match_sel)
            spr_dat_o <= {tag_mem[spr_idx], 15'd0, valid_r[spr_idx]};
         else
            spr_dat_o <= {ppn_mem[spr_idx], 10'd0, user_mem[spr_idx], we_mem[spr_idx]};
      end
   end

   // permission faults are only raised on a matching entry
   assert property (@(posedge clk) disable iff (rst) !(miss_o && pagefault_o))
      else $error("dtlb miss and pagefault raised together");

endmodule

/* source/lsu_access.sv */
`timescale 1ns/1ns
// ------------------------------
// load/store unit for the control stage
// big endian lanes and held exceptions
// ------------------------------
module lsu_access (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  padv_i,
   input  lsu_isa_pkg::lsu_op_t  op_i,
   input  logic [31:0]           phys_adr_i,
   input  logic                  tlb_miss_i,
   input  logic                  tlb_pagefault_i,
   output mem_bus_pkg::bus_req_t bus_req_o,
   input  mem_bus_pkg::bus_rsp_t bus_rsp_i,
   output logic [31:0]           result_o,
   output logic                  valid_o,
   output lsu_isa_pkg::lsu_exc_t exc_o
);
   import lsu_isa_pkg::*;

   logic        access;
   logic        is_byte;
   logic        is_half;
   logic        is_word;
   logic        align_err;
   logic        miss_now;
   logic        pf_now;
   logic        done_r;     // access acked and waiting for padv
   logic        dbus_r;
   logic        miss_r;
   logic        pf_r;
   logic [3:0]  bsel;
   logic [31:0] st_dat;
   logic [31:0] ld_aligned;
   logic [31:0] ld_ext;
   logic [31:0] result_r;

   assign access  = op_i.load | op_i.store;
   assign is_byte = op_i.opc inside {opc_lbz, opc_lbs, opc_sb};
   assign is_half = op_i.opc inside {opc_lhz, opc_lhs, opc_sh};
   assign is_word = op_i.opc inside {opc_lwz, opc_lws, opc_sw};

   assign align_err = access & ((is_word & |phys_adr_i[1:0]) | (is_half & phys_adr_i[0]));
   assign miss_now  = access & tlb_miss_i;
   assign pf_now    = access & tlb_pagefault_i;

   always_comb begin
      if (is_byte)
         bsel = 4'b1000 >> phys_adr_i[1:0];        // byte 0 on lanes 31:24
      else if (is_half)
         bsel = phys_adr_i[1] ? 4'b0011 : 4'b1100; // upper half first
      else
         bsel = 4'b1111;
   end

   // store data copied to every lane
   always_comb begin
      case (op_i.opc[1:0])
         2'b10:   st_dat = {4{op_i.rfb[7:0]}};
         2'b11:   st_dat = {2{op_i.rfb[15:0]}};
         default: st_dat = op_i.rfb;
      endcase
   end

   assign bus_req_o.req  = access & !align_err & !miss_now & !pf_now &
                           !done_r & !dbus_r & !miss_r & !pf_r;
   assign bus_req_o.we   = op_i.store;
   assign bus_req_o.bsel = bsel;
   assign bus_req_o.adr  = phys_adr_i;
   assign bus_req_o.dat  = st_dat;

   // addressed lane moved to the top then extended
   assign ld_aligned = bus_rsp_i.dat << {phys_adr_i[1:0], 3'b000};

   always_comb begin
      if (is_byte)
         ld_ext = {{24{ld_aligned[31] & !op_i.opc[0]}}, ld_aligned[31:24]};
      else if (is_half)
         ld_ext = {{16{ld_aligned[31] & !op_i.opc[0]}}, ld_aligned[31:16]};
      else
         ld_ext = ld_aligned;
   end

   always_ff @(posedge clk) begin
      if (rst | padv_i) begin   // advance retires the access
         done_r <= 1'b0;
         dbus_r <= 1'b0;
         miss_r <= 1'b0;
         pf_r   <= 1'b0;
      end else begin
         done_r <= done_r | bus_rsp_i.ack;
         dbus_r <= dbus_r | bus_rsp_i.err;
         miss_r <= miss_r | miss_now;
         pf_r   <= pf_r | pf_now;
      end
   end

   always_ff @(posedge clk) begin
      if (bus_rsp_i.ack & op_i.load)
         result_r <= ld_ext;   // bus data goes away after the ack
   end

   assign result_o = done_r ? result_r : ld_ext;
   assign valid_o  = bus_rsp_i.ack | done_r;

   assign exc_o.align     = align_err;
   assign exc_o.dbus      = bus_rsp_i.err | dbus_r;
   assign exc_o.dtlb_miss = miss_now | miss_r;
   assign exc_o.pagefault = pf_now | pf_r;

   assert property (@(posedge clk) disable iff (rst) bus_req_o.req |-> !exc_o.align)
      else $error("bus request issued for a misaligned access");

   assert property (@(posedge clk) disable iff (rst) bus_req_o.req |-> bus_req_o.bsel != 4'b0000)
      else $error("bus request with no byte lanes");

endmodule

/* source/ifetch_port.sv */
`timescale 1ns/1ns
// ------------------------------
// single word instruction fetch requester
// ------------------------------
module ifetch_port (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  stb_i,
   input  logic [31:0]           pc_i,
   output mem_bus_pkg::bus_req_t bus_req_o,
   input  mem_bus_pkg::bus_rsp_t bus_rsp_i,
   output logic [31:0]           insn_o,
   output logic                  valid_o
);
   logic        busy_r;   // request outstanding
   logic [31:0] pc_r;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy_r  <= 1'b0;
         valid_o <= 1'b0;
      end else begin
         valid_o <= busy_r & bus_rsp_i.ack;   // one pulse per fetch
         if (!busy_r)
            busy_r <= stb_i;
         else if (bus_rsp_i.ack | bus_rsp_i.err)
            busy_r <= 1'b0;                   // back to idle on any answer
      end
   end

   always_ff @(posedge clk) begin
      if (stb_i & !busy_r)
         pc_r <= pc_i;
      if (busy_r & bus_rsp_i.ack)
         insn_o <= bus_rsp_i.dat;
   end

   assign bus_req_o.req  = busy_r;
   assign bus_req_o.we   = 1'b0;
   assign bus_req_o.bsel = 4'b1111;   // whole word
   assign bus_req_o.adr  = pc_r;
   assign bus_req_o.dat  = '0;

   // strobes during a fetch are dropped
   assert property (@(posedge clk) disable iff (rst) busy_r |-> !stb_i)
      else $error("fetch strobe ignored while a fetch is outstanding");

endmodule

/* source/bus_arbiter.sv */
`timescale 1ns/1ns
// ------------------------------
// round robin arbiter for two bus masters
// ------------------------------
module bus_arbiter (
   input  logic                  clk,
   input  logic                  rst,
   input  mem_bus_pkg::bus_req_t req_a_i,
   input  mem_bus_pkg::bus_req_t req_b_i,
   output mem_bus_pkg::bus_rsp_t rsp_a_o,
   output mem_bus_pkg::bus_rsp_t rsp_b_o,
   output mem_bus_pkg::bus_req_t mem_req_o,
   input  mem_bus_pkg::bus_rsp_t mem_rsp_i
);
   logic busy_r;    // grant locked
   logic owner_r;   // set when b holds the bus
   logic rr_r;      // b wins a tie when set
   logic grant_b;
   logic sel_b;
   logic done;

   assign grant_b = req_b_i.req & (!req_a_i.req | rr_r);
   assign sel_b   = busy_r ? owner_r : grant_b;   // idle grant is combinational
   assign done    = mem_rsp_i.ack | mem_rsp_i.err;

   assign mem_req_o = sel_b ? req_b_i : req_a_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy_r  <= 1'b0;
         owner_r <= 1'b0;
         rr_r    <= 1'b0;
      end else if (busy_r) begin
         if (done) begin
            busy_r <= 1'b0;
            rr_r   <= !owner_r;   // other side goes first next
         end
      end else if (mem_req_o.req) begin
         busy_r  <= 1'b1;
         owner_r <= grant_b;
      end
   end

   // answer steered to the owner only
   always_comb begin
      rsp_a_o     = mem_rsp_i;
      rsp_b_o     = mem_rsp_i;
      rsp_a_o.ack = mem_rsp_i.ack & busy_r & !owner_r;
      rsp_a_o.err = mem_rsp_i.err & busy_r & !owner_r;
      rsp_b_o.ack = mem_rsp_i.ack & busy_r & owner_r;
      rsp_b_o.err = mem_rsp_i.err & busy_r & owner_r;
   end

   // a slave answer with no locked owner would be lost to both masters
   assert property (@(posedge clk) disable iff (rst) done |-> busy_r)
      else $error("memory response with no bus owner");

endmodule

/* source/data_ram.sv */
`timescale 1ns/1ns
// ------------------------------
// byte writable word RAM bus slave
// ------------------------------
module data_ram (
   input  logic                  clk,
   input  logic                  rst,
   input  mem_bus_pkg::bus_req_t req_i,
   output mem_bus_pkg::bus_rsp_t rsp_o
);
   import mem_bus_pkg::*;

   logic [31:0]                  mem [ram_words];
   logic [$clog2(ram_words)-1:0] idx;
   logic                         in_range;
   logic                         fire;
   logic                         ack_r;
   logic                         err_r;
   logic [31:0]                  dat_r;

   assign idx      = req_i.adr[$clog2(ram_words)+1:2];
   assign in_range = req_i.adr < 32'(ram_words * 4);
   assign fire     = req_i.req & !ack_r & !err_r;   // one answer per request

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_r <= 1'b0;
         err_r <= 1'b0;
      end else begin
         ack_r <= fire & in_range;
         err_r <= fire & !in_range;   // beyond 1 KiB
      end
   end

   always_ff @(posedge clk) begin
      if (fire & in_range) begin
         dat_r <= mem[idx];
         for (int i = 0; i < 4; i++) begin
            if (req_i.we & req_i.bsel[i])
               mem[idx][8*i +: 8] <= req_i.dat[8*i +: 8];
         end
      end
   end

   assign rsp_o.ack = ack_r;
   assign rsp_o.err = err_r;
   assign rsp_o.dat = dat_r;

endmodule

/* source/lsu_subsys_top.sv */
`timescale 1ns/1ns
// ------------------------------
// LSU with data TLB and fetch port
// sharing one RAM through an arbiter
// ------------------------------
module lsu_subsys_top (
   input  logic                  clk,
   input  logic                  rst,
   input  lsu_isa_pkg::lsu_op_t  lsu_op_i,
   input  logic                  padv_i,
   input  logic                  dmmu_enable_i,
   input  logic                  supervisor_i,
   input  lsu_isa_pkg::spr_req_t spr_i,
   input  logic                  fetch_stb_i,
   input  logic [31:0]           fetch_pc_i,
   output logic [31:0]           lsu_result_o,
   output logic                  lsu_valid_o,
   output lsu_isa_pkg::lsu_exc_t lsu_exc_o,
   output logic [31:0]           spr_dat_o,
   output logic                  spr_ack_o,
   output logic [31:0]           fetch_insn_o,
   output logic                  fetch_valid_o
);
   import mem_bus_pkg::*;

   logic [31:0] phys_adr;
   logic        tlb_miss;
   logic        tlb_pagefault;
   bus_req_t    lsu_req;
   bus_req_t    fetch_req;
   bus_req_t    mem_req;
   bus_rsp_t    lsu_rsp;
   bus_rsp_t    fetch_rsp;
   bus_rsp_t    mem_rsp;

   lsu_dtlb u_dtlb (
      .clk          (clk),
      .rst          (rst),
      .enable_i     (dmmu_enable_i),
      .supervisor_i (supervisor_i),
      .virt_adr_i   (lsu_op_i.adr),
      .store_i      (lsu_op_i.store),
      .access_i     (lsu_op_i.load | lsu_op_i.store),
      .spr_i        (spr_i),
      .spr_dat_o    (spr_dat_o),
      .spr_ack_o    (spr_ack_o),
      .phys_adr_o   (phys_adr),
      .miss_o       (tlb_miss),
      .pagefault_o  (tlb_pagefault)
   );

   lsu_access u_lsu (
      .clk             (clk),
      .rst             (rst),
      .padv_i          (padv_i),
      .op_i            (lsu_op_i),
      .phys_adr_i      (phys_adr),
      .tlb_miss_i      (tlb_miss),
      .tlb_pagefault_i (tlb_pagefault),
      .bus_req_o       (lsu_req),
      .bus_rsp_i       (lsu_rsp),
      .result_o        (lsu_result_o),
      .valid_o         (lsu_valid_o),
      .exc_o           (lsu_exc_o)
   );

   ifetch_port u_fetch (
      .clk       (clk),
      .rst       (rst),
      .stb_i     (fetch_stb_i),
      .pc_i      (fetch_pc_i),
      .bus_req_o (fetch_req),
      .bus_rsp_i (fetch_rsp),
      .insn_o    (fetch_insn_o),
      .valid_o   (fetch_valid_o)
   );

   // LSU on port a and fetch on port b
   bus_arbiter u_arb (
      .clk       (clk),
      .rst       (rst),
      .req_a_i   (lsu_req),
      .req_b_i   (fetch_req),
      .rsp_a_o   (lsu_rsp),
      .rsp_b_o   (fetch_rsp),
      .mem_req_o (mem_req),
      .mem_rsp_i (mem_rsp)
   );

   data_ram u_ram (
      .clk   (clk),
      .rst   (rst),
      .req_i (mem_req),
      .rsp_o (mem_rsp)
   );

endmodule

/* tb/lsu_subsys_tasks.svh */
// ------------------------------
// directed LSU tests and a big endian RAM model
// ------------------------------
`ifndef LSU_SUBSYS_TASKS_SVH
`define LSU_SUBSYS_TASKS_SVH

function automatic logic [31:0] load_model(input logic [31:0] word, input logic [1:0] off,
                                           input logic [5:0] opc);
   int          sh;
   logic [7:0]  b;
   logic [15:0] h;
   sh = 24 - 8 * int'(off);               // byte 0 is the most significant
   b  = word[sh +: 8];
   h  = off[1] ? word[15:0] : word[31:16];
   case (opc)
      opc_lbz, opc_lbs: return opc[0] ? {24'd0, b} : {{24{b[7]}}, b};
      opc_lhz, opc_lhs: return opc[0] ? {16'd0, h} : {{16{h[15]}}, h};
      default:          return word;
   endcase
endfunction

function automatic logic [31:0] store_model(input logic [31:0] old, input logic [1:0] off,
                                            input logic [5:0] opc, input logic [31:0] dat);
   logic [31:0] w;
   int          sh;
   w  = old;
   sh = 24 - 8 * int'(off);
   if (opc == opc_sb)
      w[sh +: 8] = dat[7:0];
   else if (opc == opc_sh && off[1])
      w[15:0] = dat[15:0];
   else if (opc == opc_sh)
      w[31:16] = dat[15:0];
   else
      w = dat;
   return w;
endfunction

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
   assert (got === exp) else begin
      $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_on_error("value mismatch");
   end
endtask

task automatic check_true(input logic cond, input string what);
   assert (cond === 1'b1) else begin
      $display("%s at %0t", what, $time);
      stop_on_error(what);
   end
endtask

// called on a falling edge, returns on the falling edge that shows the outcome
task automatic run_access(input logic is_store, input logic [5:0] opc,
                          input logic [31:0] adr, input logic [31:0] dat);
   int n;
   n      = 0;
   lsu_op = '{load: !is_store, store: is_store, opc: opc, adr: adr, rfb: dat};
   do begin
      @(negedge clk);
      n++;
   end while (!lsu_valid && lsu_exc == '0 && n < op_wait_cycles);
   check_true(lsu_valid || lsu_exc != '0, "LSU gave neither valid nor an exception");
endtask

task automatic retire_access();
   padv         = 1'b1;   // pipeline advance
   lsu_op.load  = 1'b0;
   lsu_op.store = 1'b0;
   @(negedge clk);
   padv = 1'b0;
   check_true(!lsu_valid && lsu_exc == '0, "LSU status not cleared by pipeline advance");
endtask

task automatic load_check(input logic [5:0] opc, input logic [31:0] adr);
   logic [31:0] exp;
   exp = load_model(model_mem[adr[9:2]], adr[1:0], opc);
   run_access(1'b0, opc, adr, 32'd0);
   check_eq("lsu_exc_o", {28'd0, lsu_exc}, 32'd0);
   check_eq("lsu_result_o", lsu_result, exp);
   @(negedge clk);   // result held until padv
   check_true(lsu_valid, "lsu_valid_o dropped before the pipeline advance");
   check_eq("lsu_result_o", lsu_result, exp);
   retire_access();
endtask

task automatic store_op(input logic [5:0] opc, input logic [31:0] adr, input logic [31:0] dat);
   run_access(1'b1, opc, adr, dat);
   check_eq("lsu_exc_o", {28'd0, lsu_exc}, 32'd0);
   model_mem[adr[9:2]] = store_model(model_mem[adr[9:2]], adr[1:0], opc, dat);
   retire_access();
endtask

task automatic exc_check(input logic is_store, input logic [5:0] opc,
                         input logic [31:0] adr, input lsu_exc_t exp);
   run_access(is_store, opc, adr, 32'hdead_beef);
   check_eq("lsu_exc_o", {28'd0, lsu_exc}, {28'd0, exp});
   repeat (2) @(negedge clk);   // must hold until padv
   check_eq("lsu_exc_o", {28'd0, lsu_exc}, {28'd0, exp});
   check_true(!lsu_valid, "lsu_valid_o raised for a faulting access");
   retire_access();
endtask

task automatic spr_access(input logic [15:0] addr, input logic we,
                          input logic [31:0] dat, output logic [31:0] rd);
   spr = '{addr: addr, we: we, stb: 1'b1, dat: dat};
   @(negedge clk);
   spr.stb = 1'b0;
   check_true(spr_ack, "no SPR acknowledge one cycle after the strobe");
   rd = spr_dat;
   @(negedge clk);   // let the ack drop
endtask

task automatic test_reset();
   check_true(!lsu_valid && !fetch_valid && !spr_ack, "status outputs not low after reset");
   check_eq("lsu_exc_o", {28'd0, lsu_exc}, 32'd0);
endtask

task automatic test_load_store();
   logic [31:0] w;
   w = $random(seed);
   for (int k = 0; k < 2; k++) begin
      store_op(opc_sw, 32'h40, k == 0 ? w : ~w);   // both signs in every lane
      for (int off = 0; off < 4; off++) begin
         load_check(opc_lbz, 32'h40 + off);
         load_check(opc_lbs, 32'h40 + off);
         if (off % 2 == 0) begin
            load_check(opc_lhz, 32'h40 + off);
            load_check(opc_lhs, 32'h40 + off);
         end
      end
      load_check(opc_lwz, 32'h40);
      load_check(opc_lws, 32'h40);
   end
   store_op(opc_sw, 32'h44, $random(seed));
   store_op(opc_sb, 32'h45, $random(seed));
   load_check(opc_lwz, 32'h44);
   store_op(opc_sh, 32'h46, $random(seed));
   load_check(opc_lwz, 32'h44);
endtask

task automatic test_misaligned();
   exc_check(1'b0, opc_lhz, 32'h41, exc_align);
   exc_check(1'b0, opc_lws, 32'h42, exc_align);
   exc_check(1'b1, opc_sw, 32'h43, exc_align);
   exc_check(1'b1, opc_sh, 32'h45, exc_align);
   load_check(opc_lwz, 32'h40);   // memory untouched
   load_check(opc_lwz, 32'h44);
endtask

task automatic test_bus_error();
   exc_check(1'b0, opc_lwz, 32'h400, exc_dbus);
   exc_check(1'b1, opc_sb, 32'h0000_1003, exc_dbus);
   load_check(opc_lwz, 32'h40);
endtask

task automatic test_tlb();
   logic [31:0] rd;
   // both pages map to physical page 0
   spr_access(spr_dtlb_match_base + 16'd5, 1'b1, {16'h1234, 15'd0, 1'b1}, rd);
   spr_access(spr_dtlb_trans_base + 16'd5, 1'b1, 32'h0000_0002, rd);   // user, read only
   spr_access(spr_dtlb_match_base + 16'd6, 1'b1, {16'h1234, 15'd0, 1'b1}, rd);
   spr_access(spr_dtlb_trans_base + 16'd6, 1'b1, 32'h0000_0001, rd);   // supervisor, writable
   spr_access(spr_dtlb_match_base + 16'd5, 1'b0, 32'd0, rd);
   check_eq("spr_dat_o", rd, {16'h1234, 15'd0, 1'b1});
   spr_access(spr_dtlb_trans_base + 16'd6, 1'b0, 32'd0, rd);
   check_eq("spr_dat_o", rd, 32'h0000_0001);
   dmmu_enable = 1'b1;
   load_check(opc_lwz, 32'h1234_5040);                 // same offset as physical 0x40
   exc_check(1'b0, opc_lwz, 32'h5678_5040, exc_miss);  // tag mismatch
   exc_check(1'b1, opc_sw, 32'h1234_5040, exc_pf);
   supervisor = 1'b0;
   load_check(opc_lhz, 32'h1234_5042);
   exc_check(1'b0, opc_lwz, 32'h1234_6040, exc_pf);
   supervisor  = 1'b1;
   dmmu_enable = 1'b0;
endtask

task automatic test_contention();
   logic [31:0] exp_ld;
   logic        ld_seen;
   logic        insn_seen;
   int          n;
   store_op(opc_sw, 32'h80, $random(seed));   // instruction word
   exp_ld    = load_model(model_mem[32'h44 >> 2], 2'd0, opc_lwz);
   ld_seen   = 1'b0;
   insn_seen = 1'b0;
   n         = 0;
   fetch_pc  = 32'h80;
   fetch_stb = 1'b1;
   lsu_op    = '{load: 1'b1, store: 1'b0, opc: opc_lwz, adr: 32'h44, rfb: 32'd0};
   while (!(ld_seen && insn_seen) && n < op_wait_cycles) begin
      @(negedge clk);
      fetch_stb = 1'b0;
      n++;
      if (lsu_valid && !ld_seen) begin
         check_eq("lsu_result_o", lsu_result, exp_ld);
         ld_seen = 1'b1;
      end
      if (fetch_valid) begin
         check_eq("fetch_insn_o", fetch_insn, model_mem[32'h80 >> 2]);
         insn_seen = 1'b1;
      end
   end
   check_true(ld_seen && insn_seen, "load and fetch did not both complete");
   retire_access();
endtask

`endif

/* tb/lsu_subsys_tb.sv */
`timescale 1ns/1ns
// ------------------------------
// testbench for the LSU subsystem
// ------------------------------
module lsu_subsys_tb;
   import lsu_isa_pkg::*;
   import mem_bus_pkg::*;

   localparam int op_wait_cycles  = 20;                        // bound per access
   localparam int watchdog_cycles = 80 * op_wait_cycles + 400; // about 80 accesses

   localparam lsu_exc_t exc_align = '{align: 1'b1, default: 1'b0};
   localparam lsu_exc_t exc_dbus  = '{dbus: 1'b1, default: 1'b0};
   localparam lsu_exc_t exc_miss  = '{dtlb_miss: 1'b1, default: 1'b0};
   localparam lsu_exc_t exc_pf    = '{pagefault: 1'b1, default: 1'b0};

   logic        clk = 1'b0;
   logic        rst;
   lsu_op_t     lsu_op;
   logic        padv;
   logic        dmmu_enable;
   logic        supervisor;
   spr_req_t    spr;
   logic        fetch_stb;
   logic [31:0] fetch_pc;
   logic [31:0] lsu_result;
   logic        lsu_valid;
   lsu_exc_t    lsu_exc;
   logic [31:0] spr_dat;
   logic        spr_ack;
   logic [31:0] fetch_insn;
   logic        fetch_valid;
   logic [31:0] model_mem [ram_words];   // expected RAM words
   integer      seed = 58045;

   always #5 clk = ~clk;   // 10 ns period

   lsu_subsys_top dut_i (
      .clk           (clk),
      .rst           (rst),
      .lsu_op_i      (lsu_op),
      .padv_i        (padv),
      .dmmu_enable_i (dmmu_enable),
      .supervisor_i  (supervisor),
      .spr_i         (spr),
      .fetch_stb_i   (fetch_stb),
      .fetch_pc_i    (fetch_pc),
      .lsu_result_o  (lsu_result),
      .lsu_valid_o   (lsu_valid),
      .lsu_exc_o     (lsu_exc),
      .spr_dat_o     (spr_dat),
      .spr_ack_o     (spr_ack),
      .fetch_insn_o  (fetch_insn),
      .fetch_valid_o (fetch_valid)
   );

   task automatic stop_on_error(input string what);
      $display("Test failed");
      $fatal(1, "%s", what);
   endtask

   `include "lsu_subsys_tasks.svh"

   initial begin
      rst         = 1'b1;
      lsu_op      = '0;
      padv        = 1'b0;
      dmmu_enable = 1'b0;
      supervisor  = 1'b1;
      spr         = '0;
      fetch_stb   = 1'b0;
      fetch_pc    = '0;
      repeat (4) @(negedge clk);   // four reset edges
      rst = 1'b0;
      test_reset();
      test_load_store();
      test_misaligned();
      test_bus_error();
      test_tlb();
      test_contention();
      $display("Test completed successfully");
      $finish;
   end

   // hard stop if any wait loop fails to terminate
   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      stop_on_error("watchdog expired before the test sequence finished");
   end

endmodule

/* lsu_subsys_top.f */
+incdir+tb
source/lsu_isa_pkg.sv
source/mem_bus_pkg.sv
source/lsu_dtlb.sv
source/lsu_access.sv
source/ifetch_port.sv
source/bus_arbiter.sv
source/data_ram.sv
source/lsu_subsys_top.sv
tb/lsu_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module lsu_subsys_tb -f lsu_subsys_top.f \
   -o lsu_subsys_sim &&
./obj_dir/lsu_subsys_sim | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
